/* hw/umi_apb_cfg.svh */
`ifndef UMI_APB_CFG_SVH
`define UMI_APB_CFG_SVH

// ############################################################
// umi side widths
// ############################################################
`define UMI_AW 64          // address width
`define UMI_CW 32          // command width
`define UMI_DW 256         // data width

// ############################################################
// apb side widths
// ############################################################
`define APB_RW 64          // register width
`define APB_RAW 16         // apb address width

// group address check, GRP_AW of 0 turns it off
`define GRP_OFFSET 24      // low bit of group field
`define GRP_AW 4           // group field width
`define GRP_ID 5           // accepted group

// register bank
`define REG_COUNT 16       // number of registers
`define WAIT_CYCLES 2      // wait states per access

`endif

/* hw/umi_pkg.sv */
package umi_pkg;

   // ############################################################
   // opcodes
   // ############################################################
   typedef enum logic [4:0] {
      UMI_REQ_READ   = 5'd1,  // read request
      UMI_RESP_READ  = 5'd2,  // read response
      UMI_REQ_WRITE  = 5'd3,  // acked write
      UMI_RESP_WRITE = 5'd4,  // write ack
      UMI_REQ_POSTED = 5'd5   // write without ack
   } umi_opcode_e;

   // ############################################################
   // command field positions
   // ############################################################
   localparam int UMI_OPCODE_MSB = 4;   // opcode
   localparam int UMI_OPCODE_LSB = 0;
   localparam int UMI_PROT_MSB   = 20;  // protection bits
   localparam int UMI_PROT_LSB   = 19;
   localparam int UMI_ERR_MSB    = 26;  // response error
   localparam int UMI_ERR_LSB    = 25;

   // bits 24:5 and 31:27 pass from request to response unchanged

   // requests the bridge turns into an apb transfer
   function automatic logic umi_is_supported(input logic [4:0] op);
      logic ok;
      case (op)
         UMI_REQ_READ:   ok = 1'b1;
         UMI_REQ_WRITE:  ok = 1'b1;
         UMI_REQ_POSTED: ok = 1'b1;
         default:        ok = 1'b0;  // atomics and the rest
      endcase
      return ok;
   endfunction

endpackage

/* hw/apb_if.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

interface apb_if;

   logic [`APB_RAW-1:0]  paddr;    // byte address
   logic                 pwrite;   // 1 is write
   logic [`APB_RW-1:0]   pwdata;   // write data
   logic [`APB_RW/8-1:0] pstrb;    // byte strobes
   logic [2:0]           pprot;    // protection type
   logic                 psel;     // select
   logic                 penable;  // access phase
   logic                 pready;   // completer done
   logic [`APB_RW-1:0]   prdata;   // read data
   logic                 pslverr;  // completer error

   // bridge side
   modport requester (
      output paddr, pwrite, pwdata, pstrb, pprot, psel, penable,
      input  pready, prdata, pslverr
   );

   // register bank side
   modport completer (
      input  paddr, pwrite, pwdata, pstrb, pprot, psel, penable,
      output pready, prdata, pslverr
   );

endinterface

/* hw/umi_apb_bridge.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

module umi_apb_bridge (
   input  logic              apb_pclk,      // apb clock
   input  logic              apb_nreset,    // async, active low
   // umi request
   input  logic              req_valid,
   input  logic [`UMI_CW-1:0] req_cmd,
   input  logic [`UMI_AW-1:0] req_dstaddr,
   input  logic [`UMI_AW-1:0] req_srcaddr,
   input  logic [`UMI_DW-1:0] req_data,
   output logic              req_ready,
   // umi response
   output logic              resp_valid,
   output logic [`UMI_CW-1:0] resp_cmd,
   output logic [`UMI_AW-1:0] resp_dstaddr,
   output logic [`UMI_AW-1:0] resp_srcaddr,
   output logic [`UMI_DW-1:0] resp_data,
   input  logic              resp_ready,
   // apb requester side
   apb_if.requester          apb
);

   import umi_pkg::*;

   localparam logic [31:0] GRP_ID_V = `GRP_ID;  // sized copy of the group id

   logic                 accept;       // handshake, dropped or not
   logic                 group_match;  // group field hits
   logic                 supported;    // opcode we can map
   logic                 incoming_req; // starts an apb transfer
   logic                 apb_done;     // access phase ends this edge

   logic [`UMI_CW-1:0]   cmd_r;        // held request
   logic [`UMI_AW-1:0]   dstaddr_r;
   logic [`UMI_AW-1:0]   srcaddr_r;
   logic [`APB_RW-1:0]   data_r;

   logic [`UMI_CW-1:0]   cur_cmd;      // live or held command
   logic [4:0]           cur_op;
   logic [4:0]           held_op;      // opcode of held request
   logic                 posted_r;     // held request is posted

   logic [`APB_RW-1:0]   prdata_r;     // captured read data
   logic                 pslverr_r;    // captured slave error
   logic [4:0]           resp_op;

   // ############################################################
   // request decode
   // ############################################################
   generate
      if (`GRP_AW != 0) begin : g_grp
         assign group_match =
            (req_dstaddr[`GRP_OFFSET +: `GRP_AW] == GRP_ID_V[`GRP_AW-1:0]);
      end else begin : g_nogrp
         assign group_match = 1'b1;  // check disabled
      end
   endgenerate

   assign supported    = umi_is_supported(req_cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB]);
   assign req_ready    = ~apb.penable & ~resp_valid;  // one in flight
   assign accept       = req_valid & req_ready;
   assign incoming_req = accept & group_match & supported;  // else dropped

   always_ff @(posedge apb_pclk) begin
      if (incoming_req) begin
         cmd_r     <= req_cmd;
         dstaddr_r <= req_dstaddr;
         srcaddr_r <= req_srcaddr;
         data_r    <= req_data[`APB_RW-1:0];  // single beat only
      end
   end

   assign cur_cmd  = incoming_req ? req_cmd : cmd_r;
   assign cur_op   = cur_cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB];
   assign held_op  = cmd_r[UMI_OPCODE_MSB:UMI_OPCODE_LSB];
   assign posted_r = (held_op == UMI_REQ_POSTED);

   // ############################################################
   // apb setup and access
   // ############################################################
   assign apb.psel   = incoming_req | apb.penable;  // setup is combinational
   assign apb.paddr  = incoming_req ? req_dstaddr[`APB_RAW-1:0] : dstaddr_r[`APB_RAW-1:0];
   assign apb.pwdata = incoming_req ? req_data[`APB_RW-1:0] : data_r;
   assign apb.pwrite = (cur_op == UMI_REQ_WRITE) | (cur_op == UMI_REQ_POSTED);
   assign apb.pprot  = {1'b0, cur_cmd[UMI_PROT_MSB:UMI_PROT_LSB]};
   assign apb.pstrb  = {(`APB_RW/8){1'b1}};  // full words only

   assign apb_done = apb.penable & apb.pready;

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         apb.penable <= 1'b0;
      end else if (incoming_req) begin
         apb.penable <= 1'b1;    // access after setup
      end else if (apb.pready) begin
         apb.penable <= 1'b0;
      end
   end

   // ############################################################
   // response
   // ############################################################
   always_ff @(posedge apb_pclk) begin
      if (apb_done) begin
         prdata_r  <= apb.prdata;
         pslverr_r <= apb.pslverr;
      end
   end

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         resp_valid <= 1'b0;
      end else if (apb_done & ~posted_r) begin
         resp_valid <= 1'b1;     // posted writes stay silent
      end else if (resp_ready) begin
         resp_valid <= 1'b0;     // held until taken
      end
   end

   assign resp_op = (held_op == UMI_REQ_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;

   // error field carries the slave error in its upper bit
   assign resp_cmd = {cmd_r[`UMI_CW-1:UMI_ERR_MSB+1],
                      pslverr_r, 1'b0,
                      cmd_r[UMI_ERR_LSB-1:UMI_OPCODE_MSB+1],
                      resp_op};

   assign resp_dstaddr = srcaddr_r;  // back to the sender
   assign resp_srcaddr = dstaddr_r;
   assign resp_data    = {{(`UMI_DW-`APB_RW){1'b0}}, prdata_r};

endmodule

/* hw/apb_regfile.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

module apb_regfile (
   input  logic      apb_pclk,    // apb clock
   input  logic      apb_nreset,  // async, active low
   apb_if.completer  apb          // from the bridge
);

   localparam int IDX_LSB = $clog2(`APB_RW/8);             // bytes per word
   localparam int IW      = $clog2(`REG_COUNT);            // register index bits
   localparam int WCW     = (`WAIT_CYCLES > 0) ? $clog2(`WAIT_CYCLES + 1) : 1;

   logic [`APB_RW-1:0]         regs [`REG_COUNT];  // the bank
   logic [`APB_RAW-IDX_LSB-1:0] word_idx;          // paddr in words
   logic [IW-1:0]              reg_sel;
   logic                       in_range;
   logic [WCW-1:0]             wait_cnt;           // access cycles so far
   logic                       setup;              // setup phase
   logic                       access;             // access phase
   logic                       wr_en;

   // ############################################################
   // address decode
   // ############################################################
   assign word_idx = apb.paddr[`APB_RAW-1:IDX_LSB];
   assign reg_sel  = word_idx[IW-1:0];
   assign in_range = (word_idx < `REG_COUNT);

   assign setup  = apb.psel & ~apb.penable;
   assign access = apb.psel & apb.penable;

   // ############################################################
   // wait states
   // ############################################################
   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         wait_cnt <= '0;
      end else if (access & ~apb.pready) begin
         wait_cnt <= wait_cnt + 1'b1;  // still stalling
      end else begin
         wait_cnt <= '0;               // idle or done
      end
   end

   assign apb.pready = (wait_cnt == WCW'(`WAIT_CYCLES));

   // read data and error are ready before the access ends
   always_ff @(posedge apb_pclk) begin
      if (setup) begin
         apb.prdata <= in_range ? regs[reg_sel] : '0;  // zero when out of range
      end
   end

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         apb.pslverr <= 1'b0;
      end else if (setup) begin
         apb.pslverr <= ~in_range;
      end
   end

   // ############################################################
   // register bank
   // ############################################################
   assign wr_en = access & apb.pready & apb.pwrite & in_range;  // completing edge

   always_ff @(posedge apb_pclk or negedge apb_nreset) begin
      if (!apb_nreset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < `APB_RW/8; b++) begin
            if (apb.pstrb[b]) begin
               regs[reg_sel][8*b +: 8] <= apb.pwdata[8*b +: 8];  // per byte lane
            end
         end
      end
   end

endmodule

/* hw/umi_apb_top.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

module umi_apb_top (
   input  logic               apb_pclk,      // apb clock
   input  logic               apb_nreset,    // async, active low
   // umi request in
   input  logic               req_valid,
   input  logic [`UMI_CW-1:0] req_cmd,
   input  logic [`UMI_AW-1:0] req_dstaddr,
   input  logic [`UMI_AW-1:0] req_srcaddr,
   input  logic [`UMI_DW-1:0] req_data,
   output logic               req_ready,
   // umi response out
   output logic               resp_valid,
   output logic [`UMI_CW-1:0] resp_cmd,
   output logic [`UMI_AW-1:0] resp_dstaddr,
   output logic [`UMI_AW-1:0] resp_srcaddr,
   output logic [`UMI_DW-1:0] resp_data,
   input  logic               resp_ready
);

   // ############################################################
   // bridge to register bank
   // ############################################################
   apb_if apb_i ();  // internal apb bus

   umi_apb_bridge u_bridge (
      .apb_pclk     (apb_pclk),
      .apb_nreset   (apb_nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .apb          (apb_i.requester)
   );

   apb_regfile u_regfile (
      .apb_pclk   (apb_pclk),
      .apb_nreset (apb_nreset),
      .apb        (apb_i.completer)
   );

endmodule

/* bench/tb_checker.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

module tb_checker (
   input  logic               apb_pclk,
   input  logic               apb_nreset,
   input  logic               req_valid,
   input  logic               req_ready,
   input  logic [`UMI_CW-1:0] req_cmd,
   input  logic [`UMI_AW-1:0] req_dstaddr,
   input  logic [`UMI_AW-1:0] req_srcaddr,
   input  logic [`UMI_DW-1:0] req_data,
   input  logic               resp_valid,
   input  logic               resp_ready,
   input  logic [`UMI_CW-1:0] resp_cmd,
   input  logic [`UMI_AW-1:0] resp_dstaddr,
   input  logic [`UMI_AW-1:0] resp_srcaddr,
   input  logic [`UMI_DW-1:0] resp_data,
   input  logic               test_done,    // pulse once a test has drained
   input  int                 test_id,
   output int                 err_count,
   output int                 check_count,
   output int                 pending       // responses still owed
);

   import umi_pkg::*;

   logic [`APB_RW-1:0] model [`REG_COUNT];  // shadow of the register bank
   logic [`UMI_CW-1:0] exp_cmd [$];         // expected responses, oldest first
   logic [`UMI_AW-1:0] exp_dst [$];
   logic [`UMI_AW-1:0] exp_src [$];
   logic [`UMI_DW-1:0] exp_data [$];
   logic               exp_rd [$];          // data only matters on reads
   logic [`UMI_DW-1:0] d_exp;
   logic               rd_exp, hit, err;
   logic [4:0]         op;
   int                 idx, test_errs;

   // response command gets the response opcode and the slave error in its upper error bit
   function automatic logic [`UMI_CW-1:0] resp_cmd_of(input logic [`UMI_CW-1:0] cmd,
                                                      input logic slv_err);
      logic [`UMI_CW-1:0] r;
      r = cmd;
      r[4:0] = (cmd[4:0] == UMI_REQ_READ) ? UMI_RESP_READ : UMI_RESP_WRITE;
      r[26:25] = {slv_err, 1'b0};
      return r;
   endfunction

   task automatic check_field(input string name, input logic [`UMI_DW-1:0] got,
                              input logic [`UMI_DW-1:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("Mismatch %s: got %0h expected %0h", name, got, exp);
      end
   endtask

   // ############################################################
   // compare responses, then predict from accepted requests
   // ############################################################
   always @(posedge apb_pclk) begin
      if (!apb_nreset) begin
         foreach (model[i]) model[i] = '0;     // bank resets to zero
         exp_cmd.delete();
         exp_dst.delete();
         exp_src.delete();
         exp_data.delete();
         exp_rd.delete();
         err_count = 0;
         check_count = 0;
         test_errs = 0;
      end else begin
         if (resp_valid && req_ready) begin     // only one transaction in flight
            err_count++;
            $display("req_ready high while a response was still waiting");
         end
         if (resp_valid && resp_ready) begin
            if (exp_cmd.size() == 0) begin
               err_count++;
               $display("unexpected response with command %0h", resp_cmd);
            end else begin
               check_field("resp_cmd", resp_cmd, exp_cmd.pop_front());
               check_field("resp_dstaddr", resp_dstaddr, exp_dst.pop_front());
               check_field("resp_srcaddr", resp_srcaddr, exp_src.pop_front());
               d_exp = exp_data.pop_front();
               rd_exp = exp_rd.pop_front();
               if (rd_exp) check_field("resp_data", resp_data, d_exp);
            end
         end
         if (req_valid && req_ready) begin
            op = req_cmd[4:0];
            hit = (req_dstaddr[`GRP_OFFSET +: `GRP_AW] == `GRP_ID) &&
                  (op == UMI_REQ_READ || op == UMI_REQ_WRITE || op == UMI_REQ_POSTED);
            idx = int'(req_dstaddr[`APB_RAW-1:3]);  // word index
            err = (idx >= `REG_COUNT);
            if (hit && op != UMI_REQ_POSTED) begin
               exp_cmd.push_back(resp_cmd_of(req_cmd, err));
               exp_dst.push_back(req_srcaddr);     // addresses swap
               exp_src.push_back(req_dstaddr);
               exp_data.push_back(err ? '0 : {{(`UMI_DW-`APB_RW){1'b0}}, model[idx]});
               exp_rd.push_back(op == UMI_REQ_READ);
            end
            if (hit && op != UMI_REQ_READ && !err) model[idx] = req_data[`APB_RW-1:0];
         end
         if (test_done) begin
            if (exp_cmd.size() != 0) begin
               err_count += exp_cmd.size();
               $display("test %0d ended with %0d responses never returned",
                        test_id, exp_cmd.size());
               exp_cmd.delete();
               exp_dst.delete();
               exp_src.delete();
               exp_data.delete();
               exp_rd.delete();
            end
            $display("test %0d finished: %0d errors", test_id, err_count - test_errs);
            test_errs = err_count;
         end
      end
      pending = exp_cmd.size();
   end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ps
`include "umi_apb_cfg.svh"

module tb_top;

   import umi_pkg::*;

   localparam int N_REQ      = 214;             // requests over all five tests
   localparam int MAX_CYCLES = 200 * N_REQ;
   localparam logic [`GRP_AW-1:0] GRP = `GRP_ID;  // accepted group

   logic apb_pclk, apb_nreset, req_valid, req_ready, resp_valid, resp_ready;
   logic [`UMI_CW-1:0] req_cmd, resp_cmd;
   logic [`UMI_AW-1:0] req_dstaddr, req_srcaddr, resp_dstaddr, resp_srcaddr;
   logic [`UMI_DW-1:0] req_data, resp_data;
   logic stall, test_done;                      // stall turns on resp back-pressure
   logic ready_coin;                            // back-pressure draw, off the rising edge
   int   test_id, err_count, check_count, pending, seed, pick, ridx;
   int   cycles = 0;

   umi_apb_top dut_i (.*);
   tb_checker  chk_i (.*);

   initial begin
      apb_pclk = 1'b0;
      forever #50 apb_pclk = ~apb_pclk;        // 100 ns period
   end

   always @(negedge apb_pclk) ready_coin = 1'($random(seed));
   always @(posedge apb_pclk) resp_ready <= stall ? ready_coin : 1'b1;

   always @(posedge apb_pclk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   // ############################################################
   // request driver
   // ############################################################
   task automatic send_req(input logic [4:0] op, input int idx,
                           input logic [`GRP_AW-1:0] grp, input logic [63:0] wdata);
      logic [`UMI_DW-1:0] d;
      logic [`UMI_AW-1:0] a;
      logic [`UMI_CW-1:0] c;
      for (int i = 0; i < `UMI_DW / 64; i++) d[64*i +: 64] = rand64();
      d[63:0] = wdata;
      a = rand64();
      a[`GRP_OFFSET +: `GRP_AW] = grp;
      a[15:0] = 16'(idx * 8);                   // word aligned
      c = $random(seed);
      c[4:0] = op;
      @(posedge apb_pclk);
      req_valid   <= 1'b1;
      req_cmd     <= c;
      req_dstaddr <= a;
      req_srcaddr <= rand64();
      req_data    <= d;
      @(negedge apb_pclk);
      while (!req_ready) @(negedge apb_pclk);   // handshake on next edge
      @(posedge apb_pclk);
      req_valid <= 1'b0;
   endtask

   // wait for the last response, then let the checker close the test
   task automatic end_test(input int n);
      int waited;
      waited = 0;
      @(negedge apb_pclk);
      while ((pending != 0 || !req_ready) && waited < 64) begin
         @(negedge apb_pclk);
         waited++;
      end
      @(posedge apb_pclk);
      test_done <= 1'b1;
      test_id   <= n;
      @(posedge apb_pclk);
      test_done <= 1'b0;
   endtask

   initial begin
      seed = 31053;
      apb_nreset = 1'b0;
      req_valid = 1'b0;
      req_cmd = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data = '0;
      resp_ready = 1'b1;
      stall = 1'b0;
      test_done = 1'b0;
      test_id = 0;
      repeat (16) @(posedge apb_pclk);
      apb_nreset <= 1'b1;
      send_req(UMI_REQ_WRITE, 3, GRP, rand64());     // write then read back
      send_req(UMI_REQ_READ, 3, GRP, '0);
      end_test(1);
      send_req(UMI_REQ_POSTED, 7, GRP, rand64());    // silent write
      send_req(UMI_REQ_READ, 7, GRP, '0);
      end_test(2);
      send_req(UMI_REQ_WRITE, 4, GRP, rand64());
      send_req(UMI_REQ_READ, 20, GRP, '0);           // beyond the bank
      send_req(UMI_REQ_WRITE, 16, GRP, rand64());    // aliases reg 0 and is ignored
      send_req(UMI_REQ_READ, 0, GRP, '0);
      send_req(UMI_REQ_READ, 4, GRP, '0);
      end_test(3);
      send_req(UMI_REQ_WRITE, 5, GRP, rand64());
      send_req(UMI_REQ_WRITE, 5, GRP + 1'b1, rand64());  // wrong group
      send_req(5'd9, 5, GRP, rand64());                  // unsupported atomic-like opcode
      send_req(UMI_REQ_READ, 5, GRP + 1'b1, '0);
      send_req(UMI_REQ_READ, 5, GRP, '0);
      end_test(4);
      @(posedge apb_pclk);
      stall <= 1'b1;
      repeat (200) begin
         pick = {$random(seed)} % 3;
         ridx = {$random(seed)} % (`REG_COUNT + 2);  // a few out of range
         case (pick)
            0:       send_req(UMI_REQ_READ, ridx, GRP, '0);
            1:       send_req(UMI_REQ_WRITE, ridx, GRP, rand64());
            default: send_req(UMI_REQ_POSTED, ridx, GRP, rand64());
         endcase
      end
      end_test(5);
      @(negedge apb_pclk);
      $display("tests 5, checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+hw
hw/umi_pkg.sv
hw/apb_if.sv
hw/umi_apb_bridge.sv
hw/apb_regfile.sv
hw/umi_apb_top.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
